//--- sim.f
+incdir+tests
source/net_tx_pkg.sv
source/tx_sequencer.sv
source/udp_send.sv
source/ip_send.sv
source/mac_send.sv
source/gmii_send.sv
source/network_tx.sv
tests/network_tx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the udp transmit path testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module network_tx_tb -o network_tx_sim \
  && ./obj_dir/network_tx_sim | tee /dev/stderr | grep -q "Test passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tests/frame_model.svh
/*
 * frame_model
 * reference builder for the expected udp frame:
 * bitwise crc-32, ipv4 header ones-complement sum, whole frame
 */
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// one byte into a reflected crc-32, one bit at a time
function automatic logic [31:0] crc32_next(input logic [31:0] crc, input byte_t b);
  logic [31:0] c;
  logic        fb;
  c = crc;
  for (int i = 0; i < 8; i++) begin
    fb = c[0] ^ b[i];  // lsb first
    c  = c >> 1;
    if (fb) c = c ^ CRC_POLY;
  end
  return c;
endfunction

// ones-complement sum of the ten header words
function automatic logic [15:0] ones_sum(input byte_t hdr[20]);
  logic [31:0] acc;
  acc = '0;
  for (int i = 0; i < 10; i++) begin
    acc = acc + {16'h0000, hdr[2*i], hdr[2*i+1]};
  end
  while (acc[31:16] != 16'h0000) begin
    acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};  // end-around carry
  end
  return acc[15:0];
endfunction

// expected frame for the payload in pay_q, appended to exp_q
function automatic void build_frame(input int len, input mac_addr_t smac, input ip_addr_t sip,
                                    input mac_addr_t dmac, input ip_addr_t dip,
                                    input port_t dport);
  byte_t       f[$];
  byte_t       iph[20];
  length_t     udp_len;
  length_t     ip_len;
  logic [15:0] csum;
  logic [31:0] crc;
  udp_len = length_t'(len + UDP_HEADER_LEN);
  ip_len  = length_t'(len + UDP_HEADER_LEN + IP_HEADER_LEN);
  for (int i = 0; i < PREAMBLE_LEN - 1; i++) f.push_back(PREAMBLE_BYTE);
  f.push_back(SFD_BYTE);
  for (int i = 5; i >= 0; i--) f.push_back(dmac[8*i +: 8]);  // addresses msb first
  for (int i = 5; i >= 0; i--) f.push_back(smac[8*i +: 8]);
  f.push_back(ETHERTYPE_IPV4[15:8]);
  f.push_back(ETHERTYPE_IPV4[7:0]);
  // ipv4 header, checksum slot zero while summing
  iph = '{8'h45, 8'h00, ip_len[15:8], ip_len[7:0], 8'h00, 8'h00,
          IP_FLAGS_DF[15:8], IP_FLAGS_DF[7:0], IP_TTL, IP_PROTO_UDP, 8'h00, 8'h00,
          sip[31:24], sip[23:16], sip[15:8], sip[7:0],
          dip[31:24], dip[23:16], dip[15:8], dip[7:0]};
  csum    = ~ones_sum(iph);
  iph[10] = csum[15:8];
  iph[11] = csum[7:0];
  foreach (iph[i]) f.push_back(iph[i]);
  f.push_back(LOCAL_PORT[15:8]);  // udp src port
  f.push_back(LOCAL_PORT[7:0]);
  f.push_back(dport[15:8]);
  f.push_back(dport[7:0]);
  f.push_back(udp_len[15:8]);
  f.push_back(udp_len[7:0]);
  f.push_back(8'h00);  // no udp checksum
  f.push_back(8'h00);
  foreach (pay_q[i]) f.push_back(pay_q[i]);
  // fcs covers all bytes after the sfd
  crc = CRC_RESIDUE_INIT;
  for (int i = PREAMBLE_LEN; i < f.size(); i++) crc = crc32_next(crc, f[i]);
  crc = ~crc;
  for (int i = 0; i < FCS_LEN; i++) f.push_back(crc[8*i +: 8]);  // lsb byte first
  foreach (f[i]) exp_q.push_back(f[i]);
  exp_len_q.push_back(f.size());
endfunction

`endif

//--- tests/network_tx_tb.sv
/*
 * network_tx_tb
 * sends random udp payloads through the transmit path,
 * captures the phy bytes and checks them against the frame model
 */
`timescale 1ns/1ps

module network_tx_tb import net_tx_pkg::*; ();

  localparam int wait_limit = 2000;  // cycles per wait
  localparam int overhead   = PREAMBLE_LEN + MAC_HEADER_LEN + IP_HEADER_LEN
                              + UDP_HEADER_LEN + FCS_LEN;  // 54 bytes around the payload
  localparam mac_addr_t src_mac = 48'h02_00_5e_10_00_01;
  localparam ip_addr_t  src_ip  = 32'hc0_a8_01_02;
  localparam mac_addr_t mac_a   = 48'h00_1b_21_3c_4d_5e;
  localparam ip_addr_t  ip_a    = 32'hc0_a8_01_64;
  localparam port_t     port_a  = 16'd5000;
  localparam mac_addr_t mac_b   = 48'h00_50_56_aa_bb_cc;
  localparam ip_addr_t  ip_b    = 32'h0a_00_00_07;
  localparam port_t     port_b  = 16'd6001;

  logic      tx_clock;
  logic      rst;
  logic      udp_tx_request;
  length_t   udp_tx_length;
  byte_t     udp_tx_data;
  logic      udp_tx_enable;
  logic      udp_tx_active;
  logic      run;
  mac_addr_t local_mac;
  ip_addr_t  local_ip;
  mac_addr_t dest_mac;
  ip_addr_t  dest_ip;
  port_t     dest_port;
  byte_t     phy_txd;
  logic      phy_tx_en;

  integer seed;
  int     checks = 0;
  int     errors = 0;
  int     timeouts = 0;
  int     frames_compared = 0;
  int     strobe_cnt = 0;   // read strobes seen so far
  int     strobe_base = 0;  // strobes up to the last compared frame
  byte_t  pay_q[$];         // payload of the frame being built
  byte_t  feed_q[$];        // bytes still to hand out on read strobes
  byte_t  exp_q[$];
  byte_t  cap_q[$];
  int     exp_len_q[$];
  int     cap_len_q[$];
  int     gap_q[$];         // idle cycles before each captured frame

  `include "frame_model.svh"

  network_tx dut0 (
    .tx_clock(tx_clock), .rst(rst),
    .udp_tx_request(udp_tx_request), .udp_tx_length(udp_tx_length),
    .udp_tx_data(udp_tx_data), .udp_tx_enable(udp_tx_enable),
    .udp_tx_active(udp_tx_active), .run(run),
    .local_mac(local_mac), .local_ip(local_ip),
    .dest_mac(dest_mac), .dest_ip(dest_ip), .dest_port(dest_port),
    .phy_txd(phy_txd), .phy_tx_en(phy_tx_en)
  );

  initial begin
    tx_clock = 1'b0;
    forever #20 tx_clock = ~tx_clock;  // 40 ns
  end

  // --------------------
  // helpers
  // --------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic wait_for_enable();
    int n;
    n = 0;
    if (timeouts == 0) begin
      do begin
        @(negedge tx_clock);
        n++;
      end while (!udp_tx_enable && n < wait_limit);
      if (!udp_tx_enable) begin
        timeouts++;
        $display("timeout: request not accepted within %0d cycles", wait_limit);
      end
    end
  endtask

  task automatic wait_for_frames(input int total);
    int n;
    n = 0;
    while (timeouts == 0 && frames_compared < total && n < wait_limit) begin
      @(negedge tx_clock);
      n++;
    end
    if (timeouts == 0 && frames_compared < total) begin
      timeouts++;
      $display("timeout: frame %0d never finished on the phy pins", total);
    end
  endtask

  // random payload, expected frame, then request until accepted
  task automatic send_frame(input mac_addr_t emac, input ip_addr_t eip, input port_t eport);
    int len;
    len = MIN_PAYLOAD + int'($unsigned($random(seed)) % 47);  // 18 to 64
    pay_q.delete();
    for (int i = 0; i < len; i++) pay_q.push_back(byte_t'($random(seed)));
    build_frame(len, src_mac, src_ip, emac, eip, eport);
    foreach (pay_q[i]) feed_q.push_back(pay_q[i]);
    @(negedge tx_clock);
    udp_tx_request = 1'b1;
    udp_tx_length  = length_t'(len);
    wait_for_enable();
    udp_tx_request = 1'b0;  // dropped right after the accept pulse
  endtask

  task automatic compare_next_frame();
    int    n;
    int    en;
    int    gap;
    byte_t got;
    byte_t want;
    byte_t h[20];
    n   = cap_len_q.pop_front();
    gap = gap_q.pop_front();
    if (exp_len_q.size() == 0) begin
      errors++;
      $display("frame of %0d bytes on the phy pins with no request behind it", n);
      repeat (n) void'(cap_q.pop_front());
    end else begin
      en = exp_len_q.pop_front();
      check_value("phy_tx_en cycles", 32'(en), 32'(n));
      for (int i = 0; i < n || i < en; i++) begin
        if (i < n) got = cap_q.pop_front();
        if (i < en) want = exp_q.pop_front();
        if (i >= 22 && i < 42 && i < n) h[i-22] = got;  // ip header bytes
        if (i < n && i < en) check_value($sformatf("phy_txd byte %0d", i), 32'(want), 32'(got));
      end
      if (n >= 42) begin
        check_value("ip header sum", 32'h0000_ffff, 32'(ones_sum(h)));  // checksum folds in
        check_value("ip total length", 32'(en - overhead + IP_HEADER_LEN + UDP_HEADER_LEN),
                    32'({h[2], h[3]}));
      end
      check_value("udp_tx_active cycles", 32'(en - overhead), 32'(strobe_cnt - strobe_base));
      strobe_base = strobe_cnt;
      if (gap < IFG_LEN) begin
        errors++;
        $display("only %0d idle cycles before frame %0d, at least %0d needed",
                 gap, frames_compared + 1, IFG_LEN);
      end
    end
    frames_compared++;
  endtask

  // --------------------
  // payload feed, capture, compare
  // --------------------
  initial begin
    forever begin
      @(negedge tx_clock);
      if (udp_tx_active) begin  // byte taken at the next rising edge
        strobe_cnt++;
        if (feed_q.size() > 0) begin
          udp_tx_data = feed_q.pop_front();
        end else begin
          errors++;
          $display("payload read strobe at %0d ns with no payload byte left", $time);
        end
      end
    end
  end

  initial begin : capture
    int idle;
    int cur_len;
    idle    = 100000;  // nothing before the first frame
    cur_len = 0;
    forever begin
      @(negedge tx_clock);
      if (phy_tx_en) begin
        if (cur_len == 0) gap_q.push_back(idle);
        cap_q.push_back(phy_txd);
        cur_len++;
      end else begin
        if (cur_len != 0) begin  // frame just ended
          cap_len_q.push_back(cur_len);
          cur_len = 0;
          idle    = 0;
        end
        idle++;
      end
    end
  end

  initial begin
    forever begin
      @(negedge tx_clock);
      if (cap_len_q.size() > 0) compare_next_frame();
    end
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin
    seed           = 73;
    rst            = 1'b1;
    udp_tx_request = 1'b0;
    udp_tx_length  = '0;
    udp_tx_data    = '0;
    run            = 1'b0;  // destination follows inputs
    local_mac      = src_mac;
    local_ip       = src_ip;
    dest_mac       = mac_a;
    dest_ip        = ip_a;
    dest_port      = port_a;
    repeat (2) @(posedge tx_clock);  // two reset edges
    @(negedge tx_clock);
    rst = 1'b0;

    // idle outputs after reset
    repeat (4) begin
      @(negedge tx_clock);
      check_value("phy_tx_en", 32'h0, 32'(phy_tx_en));
      check_value("udp_tx_enable", 32'h0, 32'(udp_tx_enable));
      check_value("udp_tx_active", 32'h0, 32'(udp_tx_active));
    end
    run = 1'b1;

    send_frame(mac_a, ip_a, port_a);
    wait_for_frames(1);

    // new destination while run is high stays out of the frame
    @(negedge tx_clock);
    dest_mac  = mac_b;
    dest_ip   = ip_b;
    dest_port = port_b;
    send_frame(mac_a, ip_a, port_a);
    wait_for_frames(2);

    @(negedge tx_clock);
    run = 1'b0;  // reload window
    repeat (3) @(negedge tx_clock);
    run = 1'b1;
    send_frame(mac_b, ip_b, port_b);
    wait_for_frames(3);

    // second request raised as soon as the first is accepted
    send_frame(mac_b, ip_b, port_b);
    send_frame(mac_b, ip_b, port_b);
    wait_for_frames(5);

    check_value("frames never seen", 32'h0, 32'(exp_len_q.size()));
    check_value("payload bytes never read", 32'h0, 32'(feed_q.size()));
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- source/network_tx.sv
/*
 * network_tx
 * udp transmit path top: sequencer, udp, ip, mac
 * and gmii stages chained by start pulses
 */
`timescale 1ns/1ps

module network_tx import net_tx_pkg::*; (
  input  logic      tx_clock,
  input  logic      rst,
  // user side
  input  logic      udp_tx_request,
  input  length_t   udp_tx_length,
  input  byte_t     udp_tx_data,
  output logic      udp_tx_enable,
  output logic      udp_tx_active,
  input  logic      run,
  input  mac_addr_t local_mac,
  input  ip_addr_t  local_ip,
  input  mac_addr_t dest_mac,
  input  ip_addr_t  dest_ip,
  input  port_t     dest_port,
  // phy
  output byte_t     phy_txd,
  output logic      phy_tx_en
);

  // --------------------
  // interconnect
  // --------------------
  logic      frame_start;
  length_t   payload_length;
  mac_addr_t tx_dest_mac;
  ip_addr_t  tx_dest_ip;
  port_t     tx_dest_port;
  logic      gap_busy;
  logic      ip_start;       // mac -> ip
  logic      udp_start;      // ip -> udp
  length_t   udp_length;
  byte_t     udp_data;
  logic      udp_active;
  byte_t     ip_data;
  logic      ip_active;
  byte_t     mac_tx_data;
  logic      mac_tx_active;

  tx_sequencer seq_inst (
    .tx_clock(tx_clock), .rst(rst),
    .udp_tx_request(udp_tx_request), .udp_tx_length(udp_tx_length),
    .run(run), .dest_mac(dest_mac), .dest_ip(dest_ip), .dest_port(dest_port),
    .gap_busy(gap_busy), .frame_start(frame_start), .udp_tx_enable(udp_tx_enable),
    .payload_length(payload_length), .tx_dest_mac(tx_dest_mac),
    .tx_dest_ip(tx_dest_ip), .tx_dest_port(tx_dest_port)
  );

  udp_send udp_send_inst (
    .tx_clock(tx_clock), .rst(rst), .udp_start(udp_start),
    .payload_length(payload_length), .tx_dest_port(tx_dest_port),
    .udp_tx_data(udp_tx_data), .udp_tx_active(udp_tx_active),
    .udp_length(udp_length), .udp_data(udp_data), .udp_active(udp_active)
  );

  ip_send ip_send_inst (
    .tx_clock(tx_clock), .rst(rst), .ip_start(ip_start), .udp_length(udp_length),
    .udp_data(udp_data), .udp_active(udp_active), .local_ip(local_ip),
    .tx_dest_ip(tx_dest_ip), .ip_start_udp(udp_start), .ip_data(ip_data),
    .ip_active(ip_active)
  );

  mac_send mac_send_inst (
    .tx_clock(tx_clock), .rst(rst), .frame_start(frame_start),
    .tx_dest_mac(tx_dest_mac), .local_mac(local_mac), .ip_data(ip_data),
    .ip_active(ip_active), .ip_start(ip_start), .mac_tx_data(mac_tx_data),
    .mac_tx_active(mac_tx_active)
  );

  gmii_send gmii_send_inst (
    .tx_clock(tx_clock), .rst(rst), .mac_tx_data(mac_tx_data),
    .mac_tx_active(mac_tx_active), .phy_txd(phy_txd), .phy_tx_en(phy_tx_en),
    .gap_busy(gap_busy)
  );

endmodule

//--- source/gmii_send.sv
/*
 * gmii_send
 * registers the frame bytes onto the phy pins
 * and holds off the next frame for the inter-frame gap
 */
`timescale 1ns/1ps

module gmii_send import net_tx_pkg::*; (
  input  logic  tx_clock,
  input  logic  rst,
  input  byte_t mac_tx_data,
  input  logic  mac_tx_active,
  output byte_t phy_txd,
  output logic  phy_tx_en,
  output logic  gap_busy
);

  logic [3:0] gap_cnt;  // ifg cycles left

  always_ff @(posedge tx_clock) begin
    phy_txd <= mac_tx_data;
  end

  always_ff @(posedge tx_clock) begin
    if (rst) begin
      phy_tx_en <= 1'b0;
      gap_cnt   <= '0;
    end else begin
      phy_tx_en <= mac_tx_active;
      if (phy_tx_en && !mac_tx_active) gap_cnt <= 4'(IFG_LEN);  // last byte on pins
      else if (gap_cnt != 4'd0) gap_cnt <= gap_cnt - 4'd1;
    end
  end

  // frame on the pins or gap still running
  assign gap_busy = phy_tx_en || (gap_cnt != 4'd0);

  // sequencer must have held the next frame back
  a_ifg: assert property (@(posedge tx_clock) disable iff (rst)
    (gap_cnt != 4'd0) |-> !$rose(mac_tx_active))
    else $error("frame started inside inter-frame gap");

endmodule

//--- source/mac_send.sv
/*
 * mac_send
 * preamble, sfd and ethernet header, then the ip stream,
 * closed by the crc-32 frame check sequence
 */
`timescale 1ns/1ps

module mac_send import net_tx_pkg::*; (
  input  logic      tx_clock,
  input  logic      rst,
  input  logic      frame_start,
  input  mac_addr_t tx_dest_mac,
  input  mac_addr_t local_mac,
  input  byte_t     ip_data,
  input  logic      ip_active,
  output logic      ip_start,
  output byte_t     mac_tx_data,
  output logic      mac_tx_active
);

  mac_state_t   state;
  logic [3:0]   cnt;    // byte index within the current state
  logic [175:0] pre_q;  // preamble + sfd + header, msb first
  logic [31:0]  crc_q;

  // one byte of the reflected crc-32, lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input byte_t data);
    logic [31:0] c;
    c = crc ^ {24'h000000, data};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  // --------------------
  // fsm
  // --------------------
  always_ff @(posedge tx_clock) begin
    if (rst) begin
      state <= MAC_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        MAC_IDLE: begin
          cnt <= '0;
          if (frame_start) state <= MAC_PREAMBLE;
        end
        MAC_PREAMBLE: begin
          cnt <= cnt + 4'd1;
          if (cnt == 4'(PREAMBLE_LEN - 1)) begin
            cnt   <= '0;
            state <= MAC_HEADER;
          end
        end
        MAC_HEADER: begin
          cnt <= cnt + 4'd1;
          if (cnt == 4'(MAC_HEADER_LEN - 1)) state <= MAC_PAYLOAD;
        end
        MAC_PAYLOAD: begin
          // first fcs byte goes out in the cycle ip_active drops
          if (!ip_active) begin
            cnt   <= 4'd1;
            state <= MAC_FCS;
          end
        end
        MAC_FCS: begin
          cnt <= cnt + 4'd1;
          if (cnt == 4'(FCS_LEN - 1)) state <= MAC_IDLE;
        end
        default: state <= MAC_IDLE;
      endcase
    end
  end

  // --------------------
  // data path
  // --------------------
  always_ff @(posedge tx_clock) begin
    case (state)
      MAC_IDLE: begin
        pre_q <= {{7{PREAMBLE_BYTE}}, SFD_BYTE, tx_dest_mac, local_mac, ETHERTYPE_IPV4};
        crc_q <= CRC_RESIDUE_INIT;
      end
      MAC_PREAMBLE: pre_q <= pre_q << 8;  // not covered by crc
      MAC_HEADER: begin
        pre_q <= pre_q << 8;
        crc_q <= crc_byte(crc_q, mac_tx_data);
      end
      MAC_PAYLOAD: begin
        if (ip_active) crc_q <= crc_byte(crc_q, mac_tx_data);
        else crc_q <= crc_q >> 8;  // fcs byte 0 sent
      end
      MAC_FCS:  crc_q <= crc_q >> 8;
      default:  crc_q <= crc_q;
    endcase
  end

  always_comb begin
    case (state)
      MAC_PREAMBLE, MAC_HEADER: mac_tx_data = pre_q[175:168];
      MAC_PAYLOAD: mac_tx_data = ip_active ? ip_data : ~crc_q[7:0];
      MAC_FCS:     mac_tx_data = ~crc_q[7:0];  // inverted, lsb first
      default:     mac_tx_data = 8'h00;
    endcase
  end

  assign mac_tx_active = (state != MAC_IDLE);

  // ip header lands right after the ethertype
  assign ip_start = (state == MAC_HEADER) && (cnt == 4'(MAC_HEADER_LEN - 1));

  // ip stream only opens once the ethernet header is done
  a_ip_hold: assert property (@(posedge tx_clock) disable iff (rst)
    (state == MAC_HEADER) |-> !$fell(ip_active))
    else $error("ip_active fell during mac header");

endmodule

//--- source/ip_send.sv
/*
 * ip_send
 * emits the 20 byte ipv4 header with its checksum,
 * then forwards the udp byte stream
 */
`timescale 1ns/1ps

module ip_send import net_tx_pkg::*; (
  input  logic     tx_clock,
  input  logic     rst,
  input  logic     ip_start,
  input  length_t  udp_length,
  input  byte_t    udp_data,
  input  logic     udp_active,
  input  ip_addr_t local_ip,
  input  ip_addr_t tx_dest_ip,
  output logic     ip_start_udp,
  output byte_t    ip_data,
  output logic     ip_active
);

  ip_state_t    state;
  logic [4:0]   cnt;        // header byte index
  length_t      total_len;
  logic [159:0] hdr_d;      // header with zero checksum
  logic [15:0]  hdr_csum;
  logic [159:0] hdr_q;      // shifts out msb first

  // ones-complement sum over the ten 16 bit words, folded twice
  function automatic logic [15:0] ip_checksum(input logic [159:0] hdr);
    logic [19:0] sum;
    sum = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + {4'h0, hdr[16*i +: 16]};
    end
    sum = {4'h0, sum[15:0]} + {16'h0000, sum[19:16]};
    sum = {4'h0, sum[15:0]} + {16'h0000, sum[19:16]};
    return ~sum[15:0];
  endfunction

  // --------------------
  // header assembly
  // --------------------
  assign total_len = udp_length + length_t'(IP_HEADER_LEN);

  assign hdr_d = {8'h45, 8'h00, total_len,   // version/ihl, tos, length
                  16'h0000, IP_FLAGS_DF,     // id, df
                  IP_TTL, IP_PROTO_UDP,
                  16'h0000,                  // checksum slot
                  local_ip, tx_dest_ip};

  assign hdr_csum = ip_checksum(hdr_d);

  // load while idle so the frame sees one consistent header
  always_ff @(posedge tx_clock) begin
    if (state == IP_IDLE) hdr_q <= {hdr_d[159:80], hdr_csum, hdr_d[63:0]};
    else if (state == IP_HEADER) hdr_q <= hdr_q << 8;
  end

  // --------------------
  // fsm
  // --------------------
  always_ff @(posedge tx_clock) begin
    if (rst) begin
      state <= IP_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IP_IDLE: begin
          cnt <= '0;
          if (ip_start) state <= IP_HEADER;
        end
        IP_HEADER: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'(IP_HEADER_LEN - 1)) state <= IP_PAYLOAD;
        end
        IP_PAYLOAD: if (!udp_active) state <= IP_IDLE;  // udp stream ended
        default:    state <= IP_IDLE;
      endcase
    end
  end

  // udp header follows the last ip header byte directly
  assign ip_start_udp = (state == IP_HEADER) && (cnt == 5'(IP_HEADER_LEN - 1));

  assign ip_data   = (state == IP_PAYLOAD) ? udp_data : hdr_q[159:152];
  assign ip_active = (state == IP_HEADER) || (state == IP_PAYLOAD && udp_active);

  // mac side must not restart a packet mid-flight
  a_no_restart: assert property (@(posedge tx_clock) disable iff (rst)
    ip_start |-> !ip_active)
    else $error("ip_start while ip stream active");

endmodule

//--- source/udp_send.sv
/*
 * udp_send
 * emits the 8 byte udp header, then strobes the user
 * payload in and forwards it one cycle later
 */
`timescale 1ns/1ps

module udp_send import net_tx_pkg::*; (
  input  logic    tx_clock,
  input  logic    rst,
  input  logic    udp_start,
  input  length_t payload_length,
  input  port_t   tx_dest_port,
  input  byte_t   udp_tx_data,
  output logic    udp_tx_active,
  output length_t udp_length,
  output byte_t   udp_data,
  output logic    udp_active
);

  length_t     cnt;    // index of byte on udp_data
  logic [63:0] hdr_q;  // header bytes still to go, msb first

  assign udp_length = payload_length + length_t'(UDP_HEADER_LEN);

  // --------------------
  // control
  // --------------------
  always_ff @(posedge tx_clock) begin
    if (rst) begin
      udp_active <= 1'b0;
      cnt        <= '0;
    end else if (udp_start) begin
      udp_active <= 1'b1;  // byte 0 out next cycle
      cnt        <= '0;
    end else if (udp_active) begin
      cnt <= cnt + 16'd1;
      if (cnt == udp_length - 16'd1) udp_active <= 1'b0;  // last byte out
    end
  end

  // next output byte is payload -> read strobe
  assign udp_tx_active = udp_active
                         && (cnt >= length_t'(UDP_HEADER_LEN - 1))
                         && (cnt < udp_length - 16'd1);

  // --------------------
  // data path
  // --------------------
  always_ff @(posedge tx_clock) begin
    if (udp_start) begin
      udp_data <= LOCAL_PORT[15:8];
      // src port lo, dst port, length, zero checksum
      hdr_q    <= {LOCAL_PORT[7:0], tx_dest_port, udp_length, 16'h0000, 8'h00};
    end else begin
      hdr_q    <= hdr_q << 8;
      udp_data <= udp_tx_active ? udp_tx_data : hdr_q[63:56];
    end
  end

endmodule

//--- source/tx_sequencer.sv
/*
 * tx_sequencer
 * turns a held udp request into one frame start pulse,
 * latches destination and length, waits out frame and gap
 */
`timescale 1ns/1ps

module tx_sequencer import net_tx_pkg::*; (
  input  logic      tx_clock,
  input  logic      rst,
  input  logic      udp_tx_request,
  input  length_t   udp_tx_length,
  input  logic      run,
  input  mac_addr_t dest_mac,
  input  ip_addr_t  dest_ip,
  input  port_t     dest_port,
  input  logic      gap_busy,
  output logic      frame_start,
  output logic      udp_tx_enable,
  output length_t   payload_length,
  output mac_addr_t tx_dest_mac,
  output ip_addr_t  tx_dest_ip,
  output port_t     tx_dest_port
);

  seq_state_t state;
  logic       frame_seen;  // gap_busy went high for this frame

  always_ff @(posedge tx_clock) begin
    if (rst) begin
      state      <= SEQ_IDLE;
      frame_seen <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE:  if (udp_tx_request && !gap_busy) state <= SEQ_READY;
        SEQ_READY: state <= SEQ_START;
        SEQ_START: begin
          state      <= SEQ_BUSY;
          frame_seen <= 1'b0;
        end
        SEQ_BUSY: begin
          if (gap_busy) frame_seen <= 1'b1;         // frame on the wire
          else if (frame_seen) state <= SEQ_IDLE;  // frame plus ifg done
        end
        default:   state <= SEQ_IDLE;
      endcase
    end
  end

  // destination follows inputs until run is set, then frozen
  always_ff @(posedge tx_clock) begin
    if (!run) begin
      tx_dest_mac  <= dest_mac;
      tx_dest_ip   <= dest_ip;
      tx_dest_port <= dest_port;
    end
    if (state == SEQ_READY) payload_length <= udp_tx_length;
  end

  assign frame_start   = (state == SEQ_START);  // one cycle
  assign udp_tx_enable = (state == SEQ_START);  // user ack, same cycle

  // length seen at acceptance is what gets latched, and it must be legal
  a_len_range: assert property (@(posedge tx_clock) disable iff (rst)
    (state == SEQ_IDLE && udp_tx_request && !gap_busy) |-> ##2
    (payload_length >= length_t'(MIN_PAYLOAD) && payload_length <= length_t'(MAX_PAYLOAD)))
    else $error("payload length out of range");

endmodule

//--- source/net_tx_pkg.sv
/*
 * net_tx_pkg
 * shared widths, protocol constants and state encodings
 * for the UDP/IPv4/Ethernet transmit path
 */
package net_tx_pkg;

  // --------------------
  // field types
  // --------------------
  typedef logic [7:0]  byte_t;      // one frame byte
  typedef logic [47:0] mac_addr_t;  // ethernet address
  typedef logic [31:0] ip_addr_t;   // ipv4 address
  typedef logic [15:0] port_t;      // udp port
  typedef logic [15:0] length_t;    // payload, udp or ip length

  // --------------------
  // state encodings
  // --------------------
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_READY, SEQ_START, SEQ_BUSY} seq_state_t;

  typedef enum logic [2:0] {
    MAC_IDLE,
    MAC_PREAMBLE,
    MAC_HEADER,
    MAC_PAYLOAD,
    MAC_FCS
  } mac_state_t;

  typedef enum logic [1:0] {IP_IDLE, IP_HEADER, IP_PAYLOAD} ip_state_t;

  // --------------------
  // ethernet framing
  // --------------------
  localparam byte_t       PREAMBLE_BYTE    = 8'h55;
  localparam byte_t       SFD_BYTE         = 8'hD5;
  localparam int          PREAMBLE_LEN     = 8;     // includes sfd
  localparam int          MAC_HEADER_LEN   = 14;    // dst, src, ethertype
  localparam logic [15:0] ETHERTYPE_IPV4   = 16'h0800;
  localparam int          FCS_LEN          = 4;
  localparam logic [31:0] CRC_POLY         = 32'hEDB88320;  // reflected crc-32
  localparam logic [31:0] CRC_RESIDUE_INIT = 32'hFFFFFFFF;
  localparam int          IFG_LEN          = 12;    // idle cycles between frames

  // --------------------
  // ipv4 / udp
  // --------------------
  localparam int          IP_HEADER_LEN  = 20;
  localparam byte_t       IP_TTL         = 8'd128;
  localparam byte_t       IP_PROTO_UDP   = 8'd17;
  localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;  // don't fragment, offset 0
  localparam int          UDP_HEADER_LEN = 8;
  localparam port_t       LOCAL_PORT     = 16'd1024;

  // legal payload range, no padding for short frames
  localparam int MIN_PAYLOAD = 18;
  localparam int MAX_PAYLOAD = 1472;

endpackage
